// File: Makefile
TOP := tb_soc

.PHONY: run lint clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

obj_dir/V$(TOP): src.f $(wildcard logic/*.sv bench/*.sv)
	verilator --binary -j 0 --top-module $(TOP) -f src.f

lint:
	verilator --lint-only --timing --top-module soc_top -f src.f

clean:
	rm -rf obj_dir sim.log

// File: bench/bus_vectors.txt
# op addr data count, numbers in hex; count above 1 uses the address fill pattern, data ignored
# B: inst at addr, data at count; C: mtimecmp = mtime + count; T: wait (count+2)*FMAX, irq = data
T F0000000 00000000 00000000
W 00000000 00000000 00000020
R 00000000 00000000 00000020
I 00000040 00000000 00000010
W 00000200 CAFEF00D 00000001
R 00000200 CAFEF00D 00000001
W 00000204 13579BDF 00000001
I 00000204 13579BDF 00000001
I 00000200 CAFEF00D 00000001
W 00001300 A5A5A5A5 00000001
R 00000300 A5A5A5A5 00000001
W 00000304 5A5A5A5A 00000001
R 00002304 5A5A5A5A 00000001
W 00000FFC 0BADBEEF 00000001
R 00001FFC 0BADBEEF 00000001
R 00000000 00000000 00000004
B 00000010 00000000 00000070
B 00000044 00000000 00000008
W F000001C 11111111 00000001
R F000001C 00000000 00000001
R F0000018 00000000 00000001
C F0000000 DEAD0000 00000014
T F0000000 00000001 00000014

// File: bench/tb_soc.sv
`timescale 1ns/1ns

module tb_soc;

    localparam int FMAX_MHZ  = 4;
    localparam int MEM_WIDTH = 10;
    localparam int MEM_DELAY = 4;

    logic           clk_in;
    logic           rst_n;
    logic           i_req_valid;
    logic           i_req_ready;
    soc_pkg::addr_t i_req_addr;
    logic           i_resp_valid;
    soc_pkg::word_t i_resp_rdata;
    logic           d_req_valid;
    logic           d_req_ready;
    soc_pkg::addr_t d_req_addr;
    logic           d_req_wen;
    soc_pkg::word_t d_req_wdata;
    logic           d_resp_valid;
    soc_pkg::word_t d_resp_rdata;
    logic           timer_irq;

    logic [7:0]     op_q [$];
    soc_pkg::addr_t addr_q [$];
    soc_pkg::word_t data_q [$];
    soc_pkg::word_t cnt_q [$];
    int             cycles = 0;
    int             timeout_limit = 0;

    soc_top #(
        .FMAX_MHZ  (FMAX_MHZ),
        .MEM_WIDTH (MEM_WIDTH),
        .MEM_DELAY (MEM_DELAY)
    ) u_dut (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .i_req_valid  (i_req_valid),
        .i_req_ready  (i_req_ready),
        .i_req_addr   (i_req_addr),
        .i_resp_valid (i_resp_valid),
        .i_resp_rdata (i_resp_rdata),
        .d_req_valid  (d_req_valid),
        .d_req_ready  (d_req_ready),
        .d_req_addr   (d_req_addr),
        .d_req_wen    (d_req_wen),
        .d_req_wdata  (d_req_wdata),
        .d_resp_valid (d_resp_valid),
        .d_resp_rdata (d_resp_rdata),
        .timer_irq    (timer_irq)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input soc_pkg::word_t exp_w,
                              input soc_pkg::word_t act);
        if (act !== exp_w) begin
            report_failure($sformatf("error: %s expected %h got %h", name, exp_w, act));
        end
    endtask

    task automatic check_irq(input string name, input logic exp_l, input logic act);
        if (act !== exp_l) begin
            report_failure($sformatf("error: %s expected %h got %h", name, exp_l, act));
        end
    endtask

    function automatic soc_pkg::word_t xorshift32(input soc_pkg::word_t x);
        soc_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Fill word for one address, the same for writes and later reads
    function automatic soc_pkg::word_t fill_word(input soc_pkg::addr_t a);
        return xorshift32(32'h4585 ^ a);
    endfunction

    function automatic logic in_window(input soc_pkg::addr_t a);
        return a[31:5] == soc_pkg::MMIO_BASE[31:5];
    endfunction

    task automatic data_access(input soc_pkg::addr_t addr, input logic wen,
                               input soc_pkg::word_t wdata, output soc_pkg::word_t rdata,
                               output int resp_cycle);
        int lat;
        int exp_lat;
        exp_lat     = in_window(addr) ? 1 : MEM_DELAY;
        d_req_valid = 1'b1;
        d_req_addr  = addr;
        d_req_wen   = wen;
        d_req_wdata = wdata;
        do begin
            @(negedge clk_in);
        end while (!d_req_ready);
        @(posedge clk_in); // Acceptance edge
        #1;
        d_req_valid = 1'b0;
        d_req_wen   = 1'b0;
        lat = 0;
        do begin
            @(negedge clk_in);
            lat++;
        end while (!d_resp_valid);
        rdata      = d_resp_rdata;
        resp_cycle = cycles;
        if (lat != exp_lat) begin
            report_failure($sformatf("error: d_resp_valid latency %h expected %h", lat, exp_lat));
        end
        @(posedge clk_in);
        #1;
    endtask

    task automatic inst_read(input soc_pkg::addr_t addr, output soc_pkg::word_t rdata,
                             output int resp_cycle);
        int lat;
        i_req_valid = 1'b1;
        i_req_addr  = addr;
        do begin
            @(negedge clk_in);
        end while (!i_req_ready);
        @(posedge clk_in);
        #1;
        i_req_valid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk_in);
            lat++;
        end while (!i_resp_valid);
        rdata      = i_resp_rdata;
        resp_cycle = cycles;
        if (lat != MEM_DELAY) begin
            report_failure($sformatf("error: i_resp_valid latency %h expected %h", lat, MEM_DELAY));
        end
        @(posedge clk_in);
        #1;
    endtask

    task automatic load_vectors();
        int               fd;
        int               n;
        logic [63:0]      tok;
        logic [8*160-1:0] rest;
        soc_pkg::addr_t   a;
        soc_pkg::word_t   d;
        soc_pkg::word_t   c;
        fd = $fopen("bench/bus_vectors.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open bench/bus_vectors.txt");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tok);
            if (n == 1) begin
                if (tok[7:0] == "#") begin
                    n = $fgets(rest, fd); // Rest of a comment line
                end else begin
                    n = $fscanf(fd, "%h %h %h", a, d, c);
                    if (n != 3) begin
                        report_failure("Malformed line in bench/bus_vectors.txt");
                    end
                    op_q.push_back(tok[7:0]);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    cnt_q.push_back(c);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        wait (timeout_limit > 0);
        while (cycles <= timeout_limit) begin
            @(posedge clk_in);
        end
        report_failure("The run did not finish within the cycle limit");
    end

    initial begin
        soc_pkg::word_t  rd;
        soc_pkg::word_t  rd_i;
        soc_pkg::word_t  exp_w;
        soc_pkg::word_t  n_words;
        soc_pkg::addr_t  a;
        soc_pkg::word_t  lo;
        soc_pkg::word_t  hi;
        soc_pkg::count_t cmp;
        soc_pkg::word_t  c0;
        soc_pkg::word_t  m0;
        soc_pkg::word_t  dc;
        soc_pkg::word_t  dm;
        int              t_d;
        int              t_i;
        rst_n       = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        d_req_valid = 1'b0;
        d_req_addr  = '0;
        d_req_wen   = 1'b0;
        d_req_wdata = '0;
        load_vectors();
        timeout_limit = op_q.size() * (MEM_DELAY + 4) + 2000;
        repeat (5) @(posedge clk_in);
        #1;
        rst_n = 1'b1;
        check_irq("timer_irq", 1'b0, timer_irq);
        foreach (op_q[v]) begin
            n_words = (cnt_q[v] == 0) ? 32'd1 : cnt_q[v];
            a       = addr_q[v];
            case (op_q[v])
                "W": begin
                    for (int k = 0; k < int'(n_words); k++) begin
                        exp_w = (n_words > 1) ? fill_word(a + 32'(4 * k)) : data_q[v];
                        data_access(a + 32'(4 * k), 1'b1, exp_w, rd, t_d);
                        if (!in_window(a)) begin
                            check_word("d_resp_rdata", exp_w, rd); // Write echo
                        end
                    end
                end
                "R": begin
                    for (int k = 0; k < int'(n_words); k++) begin
                        exp_w = (n_words > 1) ? fill_word(a + 32'(4 * k)) : data_q[v];
                        data_access(a + 32'(4 * k), 1'b0, '0, rd, t_d);
                        check_word("d_resp_rdata", exp_w, rd);
                    end
                end
                "I": begin
                    for (int k = 0; k < int'(n_words); k++) begin
                        exp_w = (n_words > 1) ? fill_word(a + 32'(4 * k)) : data_q[v];
                        inst_read(a + 32'(4 * k), rd_i, t_i);
                        check_word("i_resp_rdata", exp_w, rd_i);
                    end
                end
                "B": begin
                    fork
                        data_access(cnt_q[v], 1'b0, '0, rd, t_d);
                        inst_read(a, rd_i, t_i);
                    join
                    check_word("d_resp_rdata", fill_word(cnt_q[v]), rd);
                    check_word("i_resp_rdata", fill_word(a), rd_i);
                    if (t_d >= t_i) begin
                        report_failure("The instruction response came before the data response");
                    end
                end
                "C": begin
                    data_access(a + 32'(soc_pkg::MTIME_LO), 1'b0, '0, lo, t_d);
                    data_access(a + 32'(soc_pkg::MTIME_HI), 1'b0, '0, hi, t_d);
                    cmp = {hi, lo} + 64'(cnt_q[v]);
                    data_access(a + 32'(soc_pkg::MTIMECMP_LO), 1'b1, 32'hFFFF_FFFF, rd, t_d);
                    data_access(a + 32'(soc_pkg::MTIMECMP_HI), 1'b1, cmp[63:32], rd, t_d);
                    data_access(a + 32'(soc_pkg::MTIMECMP_LO), 1'b1, cmp[31:0], rd, t_d);
                    check_irq("timer_irq", 1'b0, timer_irq);
                    data_access(a + 32'(soc_pkg::MTIMECMP_LO), 1'b0, '0, rd, t_d);
                    check_word("d_resp_rdata", cmp[31:0], rd);
                    data_access(a + 32'(soc_pkg::MTIMECMP_HI), 1'b0, '0, rd, t_d);
                    check_word("d_resp_rdata", cmp[63:32], rd);
                    data_access(a + 32'(soc_pkg::MTIME_LO), 1'b1, data_q[v], rd, t_d);
                    data_access(a + 32'(soc_pkg::MTIME_LO), 1'b0, '0, rd, t_d);
                    if (rd - lo > 32'h100) begin
                        report_failure($sformatf("error: mtime low word %h after a write of %h",
                                                 rd, data_q[v]));
                    end
                end
                "T": begin
                    data_access(a + 32'(soc_pkg::CYCLE_LO), 1'b0, '0, c0, t_d);
                    data_access(a + 32'(soc_pkg::MTIME_LO), 1'b0, '0, m0, t_d);
                    repeat ((cnt_q[v] + 32'd2) * 32'(FMAX_MHZ)) @(posedge clk_in);
                    #1;
                    check_irq("timer_irq", data_q[v][0], timer_irq);
                    data_access(a + 32'(soc_pkg::CYCLE_LO), 1'b0, '0, rd, t_d);
                    dc = rd - c0;
                    data_access(a + 32'(soc_pkg::MTIME_LO), 1'b0, '0, rd, t_d);
                    dm    = rd - m0;
                    exp_w = dc / 32'(FMAX_MHZ);
                    if (dc == 0 || dm == 0 || dm > exp_w + 1 || dm + 1 < exp_w) begin
                        report_failure($sformatf("error: mtime delta %h against cycle delta %h",
                                                 dm, dc));
                    end
                end
                default: begin
                    report_failure($sformatf("Unknown op %s in bench/bus_vectors.txt", op_q[v]));
                end
            endcase
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: logic/delayed_memory.sv
`timescale 1ns/1ns

module delayed_memory #(
    parameter int MEM_WIDTH = 10,
    parameter int MEM_DELAY = 4
) (
    input  logic           clk_in,
    input  logic           rst_n,
    input  logic           req_valid,
    output logic           req_ready,
    input  soc_pkg::addr_t req_addr,
    input  logic           req_wen,
    input  soc_pkg::word_t req_wdata,
    output logic           resp_valid,
    output soc_pkg::addr_t resp_addr,
    output soc_pkg::word_t resp_rdata
);

    localparam int CNT_W = $clog2(MEM_DELAY + 1);
    localparam int DEPTH = 2 ** MEM_WIDTH;

    soc_pkg::word_t       mem [DEPTH];
    logic [CNT_W-1:0]     delay_cnt;
    logic [MEM_WIDTH-1:0] word_idx;
    logic                 accept;
    soc_pkg::addr_t       addr_q;
    soc_pkg::word_t       rdata_q;

    assign word_idx   = req_addr[MEM_WIDTH+1:2]; // Upper address bits wrap
    assign accept     = req_valid && req_ready;
    assign req_ready  = (delay_cnt <= CNT_W'(1)); // Free again in the response cycle
    assign resp_valid = (delay_cnt == CNT_W'(1));
    assign resp_addr  = addr_q;
    assign resp_rdata = rdata_q;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            delay_cnt <= '0;
        end else if (accept) begin
            delay_cnt <= CNT_W'(MEM_DELAY);
        end else if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - CNT_W'(1);
        end
    end

    // Access happens at acceptance, the result waits out the delay
    always_ff @(posedge clk_in) begin
        if (accept) begin
            addr_q <= req_addr;
            if (req_wen) begin
                mem[word_idx] <= req_wdata;
                rdata_q       <= req_wdata; // Write echoes the new word
            end else begin
                rdata_q <= mem[word_idx];
            end
        end
    end

endmodule

// File: logic/mem_bus_arbiter.sv
`timescale 1ns/1ns

module mem_bus_arbiter (
    input  logic           clk_in,
    input  logic           rst_n,

    input  logic           i_req_valid,
    output logic           i_req_ready,
    input  soc_pkg::addr_t i_req_addr,
    output logic           i_resp_valid,
    output soc_pkg::word_t i_resp_rdata,

    input  logic           d_req_valid,
    output logic           d_req_ready,
    input  soc_pkg::addr_t d_req_addr,
    input  logic           d_req_wen,
    input  soc_pkg::word_t d_req_wdata,
    output logic           d_resp_valid,
    output soc_pkg::word_t d_resp_rdata,

    output logic           m_req_valid,
    input  logic           m_req_ready,
    output soc_pkg::addr_t m_req_addr,
    output logic           m_req_wen,
    output soc_pkg::word_t m_req_wdata,
    input  logic           m_resp_valid,
    input  soc_pkg::word_t m_resp_rdata
);

    soc_pkg::owner_e owner_q;
    logic            idle;
    logic            sel_data;
    logic            accept;

    assign idle     = (owner_q == soc_pkg::OWN_NONE);
    assign sel_data = d_req_valid; // Data wins a tie
    assign accept   = m_req_valid && m_req_ready;

    assign m_req_valid = idle && (d_req_valid || i_req_valid);
    assign m_req_addr  = sel_data ? d_req_addr : i_req_addr;
    assign m_req_wen   = sel_data && d_req_wen; // Instruction side only reads
    assign m_req_wdata = d_req_wdata;

    assign d_req_ready = idle && m_req_ready;
    assign i_req_ready = idle && !d_req_valid && m_req_ready;

    assign d_resp_valid = m_resp_valid && (owner_q == soc_pkg::OWN_DATA);
    assign i_resp_valid = m_resp_valid && (owner_q == soc_pkg::OWN_INST);
    assign d_resp_rdata = m_resp_rdata;
    assign i_resp_rdata = m_resp_rdata;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            owner_q <= soc_pkg::OWN_NONE;
        end else begin
            case (owner_q)
                soc_pkg::OWN_NONE: begin
                    if (accept) begin
                        owner_q <= sel_data ? soc_pkg::OWN_DATA : soc_pkg::OWN_INST;
                    end
                end
                soc_pkg::OWN_INST,
                soc_pkg::OWN_DATA: begin
                    if (m_resp_valid) begin
                        owner_q <= soc_pkg::OWN_NONE;
                    end
                end
                default: owner_q <= soc_pkg::OWN_NONE;
            endcase
        end
    end

endmodule

// File: logic/mmio_timer.sv
`timescale 1ns/1ns

module mmio_timer (
    input  logic            clk_in,
    input  logic            rst_n,
    input  soc_pkg::count_t cycle_count,
    input  soc_pkg::count_t mtime,

    input  logic            d_req_valid,
    output logic            d_req_ready,
    input  soc_pkg::addr_t  d_req_addr,
    input  logic            d_req_wen,
    input  soc_pkg::word_t  d_req_wdata,
    output logic            d_resp_valid,
    output soc_pkg::word_t  d_resp_rdata,

    output logic            mem_req_valid,
    input  logic            mem_req_ready,
    output soc_pkg::addr_t  mem_req_addr,
    output logic            mem_req_wen,
    output soc_pkg::word_t  mem_req_wdata,
    input  logic            mem_resp_valid,
    input  soc_pkg::word_t  mem_resp_rdata,

    output logic            timer_irq
);

    localparam int OW = soc_pkg::MMIO_OFF_W;

    logic               hit;
    logic               win_acc;
    soc_pkg::mmio_off_t win_off;
    soc_pkg::word_t     win_rdata;
    soc_pkg::count_t    mtimecmp;
    logic               win_resp_valid_q;
    soc_pkg::word_t     win_rdata_q;

    assign hit     = (d_req_addr[31:OW] == soc_pkg::MMIO_BASE[31:OW]);
    assign win_off = d_req_addr[OW-1:0];
    assign win_acc = d_req_valid && hit; // Window is always ready

    // Misses go straight on to the arbiter
    assign mem_req_valid = d_req_valid && !hit;
    assign mem_req_addr  = d_req_addr;
    assign mem_req_wen   = d_req_wen;
    assign mem_req_wdata = d_req_wdata;
    assign d_req_ready   = hit ? 1'b1 : mem_req_ready;

    always_comb begin
        case (win_off)
            soc_pkg::MTIME_LO:    win_rdata = mtime[31:0];
            soc_pkg::MTIME_HI:    win_rdata = mtime[63:32];
            soc_pkg::MTIMECMP_LO: win_rdata = mtimecmp[31:0];
            soc_pkg::MTIMECMP_HI: win_rdata = mtimecmp[63:32];
            soc_pkg::CYCLE_LO:    win_rdata = cycle_count[31:0];
            soc_pkg::CYCLE_HI:    win_rdata = cycle_count[63:32];
            default:              win_rdata = '0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            win_resp_valid_q <= 1'b0;
            mtimecmp         <= '1; // Interrupt stays off until software arms it
        end else begin
            win_resp_valid_q <= win_acc;
            if (win_acc && d_req_wen) begin
                if (win_off == soc_pkg::MTIMECMP_LO) begin
                    mtimecmp[31:0] <= d_req_wdata;
                end else if (win_off == soc_pkg::MTIMECMP_HI) begin
                    mtimecmp[63:32] <= d_req_wdata;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (win_acc) begin
            win_rdata_q <= win_rdata;
        end
    end

    // Window response takes precedence over memory
    assign d_resp_valid = win_resp_valid_q || mem_resp_valid;
    assign d_resp_rdata = win_resp_valid_q ? win_rdata_q : mem_resp_rdata;

    assign timer_irq = (mtime >= mtimecmp);

endmodule

// File: logic/soc_pkg.sv
package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [63:0] count_t;

    // Byte offset inside the 32-byte timer window
    typedef logic [4:0] mmio_off_t;

    localparam int MMIO_OFF_W = 5;

    localparam addr_t MMIO_BASE = 32'hF000_0000;

    localparam mmio_off_t MTIME_LO    = 5'h00;
    localparam mmio_off_t MTIME_HI    = 5'h04;
    localparam mmio_off_t MTIMECMP_LO = 5'h08;
    localparam mmio_off_t MTIMECMP_HI = 5'h0C;
    localparam mmio_off_t CYCLE_LO    = 5'h10;
    localparam mmio_off_t CYCLE_HI    = 5'h14;

    // Who holds the shared memory
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_INST,
        OWN_DATA
    } owner_e;

endpackage

// File: logic/soc_top.sv
`timescale 1ns/1ns

module soc_top #(
    parameter int FMAX_MHZ  = 27,
    parameter int MEM_WIDTH = 10,
    parameter int MEM_DELAY = 4
) (
    input  logic           clk_in,
    input  logic           rst_n,

    input  logic           i_req_valid,
    output logic           i_req_ready,
    input  soc_pkg::addr_t i_req_addr,
    output logic           i_resp_valid,
    output soc_pkg::word_t i_resp_rdata,

    input  logic           d_req_valid,
    output logic           d_req_ready,
    input  soc_pkg::addr_t d_req_addr,
    input  logic           d_req_wen,
    input  soc_pkg::word_t d_req_wdata,
    output logic           d_resp_valid,
    output soc_pkg::word_t d_resp_rdata,

    output logic           timer_irq
);

    soc_pkg::count_t cycle_count;
    soc_pkg::count_t mtime;

    // Data side after the MMIO window
    logic            dm_req_valid;
    logic            dm_req_ready;
    soc_pkg::addr_t  dm_req_addr;
    logic            dm_req_wen;
    soc_pkg::word_t  dm_req_wdata;
    logic            dm_resp_valid;
    soc_pkg::word_t  dm_resp_rdata;

    // Arbiter to memory
    logic            mem_req_valid;
    logic            mem_req_ready;
    soc_pkg::addr_t  mem_req_addr;
    logic            mem_req_wen;
    soc_pkg::word_t  mem_req_wdata;
    logic            mem_resp_valid;
    soc_pkg::word_t  mem_resp_rdata;

    time_base #(
        .FMAX_MHZ(FMAX_MHZ)
    ) u_time_base (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .cycle_count (cycle_count),
        .mtime       (mtime)
    );

    mmio_timer u_mmio_timer (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .cycle_count    (cycle_count),
        .mtime          (mtime),
        .d_req_valid    (d_req_valid),
        .d_req_ready    (d_req_ready),
        .d_req_addr     (d_req_addr),
        .d_req_wen      (d_req_wen),
        .d_req_wdata    (d_req_wdata),
        .d_resp_valid   (d_resp_valid),
        .d_resp_rdata   (d_resp_rdata),
        .mem_req_valid  (dm_req_valid),
        .mem_req_ready  (dm_req_ready),
        .mem_req_addr   (dm_req_addr),
        .mem_req_wen    (dm_req_wen),
        .mem_req_wdata  (dm_req_wdata),
        .mem_resp_valid (dm_resp_valid),
        .mem_resp_rdata (dm_resp_rdata),
        .timer_irq      (timer_irq)
    );

    mem_bus_arbiter u_mem_bus_arbiter (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .i_req_valid  (i_req_valid),
        .i_req_ready  (i_req_ready),
        .i_req_addr   (i_req_addr),
        .i_resp_valid (i_resp_valid),
        .i_resp_rdata (i_resp_rdata),
        .d_req_valid  (dm_req_valid),
        .d_req_ready  (dm_req_ready),
        .d_req_addr   (dm_req_addr),
        .d_req_wen    (dm_req_wen),
        .d_req_wdata  (dm_req_wdata),
        .d_resp_valid (dm_resp_valid),
        .d_resp_rdata (dm_resp_rdata),
        .m_req_valid  (mem_req_valid),
        .m_req_ready  (mem_req_ready),
        .m_req_addr   (mem_req_addr),
        .m_req_wen    (mem_req_wen),
        .m_req_wdata  (mem_req_wdata),
        .m_resp_valid (mem_resp_valid),
        .m_resp_rdata (mem_resp_rdata)
    );

    delayed_memory #(
        .MEM_WIDTH(MEM_WIDTH),
        .MEM_DELAY(MEM_DELAY)
    ) u_delayed_memory (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .req_valid  (mem_req_valid),
        .req_ready  (mem_req_ready),
        .req_addr   (mem_req_addr),
        .req_wen    (mem_req_wen),
        .req_wdata  (mem_req_wdata),
        .resp_valid (mem_resp_valid),
        .resp_addr  (),
        .resp_rdata (mem_resp_rdata)
    );

endmodule

// File: logic/time_base.sv
`timescale 1ns/1ns

module time_base #(
    parameter int FMAX_MHZ = 27
) (
    input  logic            clk_in,
    input  logic            rst_n,
    output soc_pkg::count_t cycle_count,
    output soc_pkg::count_t mtime
);

    localparam int PRE_W = (FMAX_MHZ > 1) ? $clog2(FMAX_MHZ) : 1;

    logic [PRE_W-1:0] prescale;
    logic             us_tick;

    assign us_tick = (prescale == PRE_W'(FMAX_MHZ - 1)); // One microsecond elapsed

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            prescale    <= '0;
            cycle_count <= '0;
            mtime       <= '0;
        end else begin
            cycle_count <= cycle_count + 64'd1;
            if (us_tick) begin
                prescale <= '0;
                mtime    <= mtime + 64'd1;
            end else begin
                prescale <= prescale + PRE_W'(1);
            end
        end
    end

endmodule

// File: src.f
logic/soc_pkg.sv
logic/time_base.sv
logic/delayed_memory.sv
logic/mem_bus_arbiter.sv
logic/mmio_timer.sv
logic/soc_top.sv
bench/tb_soc.sv
